/* cal/cal_coef_regs.sv */
// AXI4-Lite coefficient register file with two combinational lane lookup ports
`default_nettype none
`timescale 1ns/10ps

module cal_coef_regs (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [axil_pkg::AXIL_ADDR_W-1:0]     awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]     wdata,
    input  logic [axil_pkg::AXIL_DATA_W/8-1:0]   wstrb,
    input  logic                                 wvalid,
    output logic                                 wready,
    output axil_pkg::axil_resp_e                 bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    input  logic [axil_pkg::AXIL_ADDR_W-1:0]     araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [axil_pkg::AXIL_DATA_W-1:0]     rdata,
    output axil_pkg::axil_resp_e                 rresp,
    output logic                                 rvalid,
    input  logic                                 rready,
    input  cal_pkg::lane_chan_t                  adc_chan,
    input  cal_pkg::lane_chan_t                  dac_chan,
    output cal_pkg::coef_t                       adc_offset,
    output cal_pkg::coef_t                       adc_gain,
    output cal_pkg::coef_t                       dac_offset,
    output cal_pkg::coef_t                       dac_gain
);
    import axil_pkg::*;
    import cal_pkg::*;

    // Unity calibration, zero offset and a gain of 1.0 in 6.10
    localparam coef_t offset_reset = 16'sd0;
    localparam coef_t gain_reset = 16'sd1024;

    coef_t          coef_mem [0:COEF_WORDS-1];
    axil_wr_state_e wr_state;
    axil_rd_state_e rd_state;

    // Word index and alignment of each address channel
    logic [AXIL_ADDR_W-AXIL_WORD_LSB-1:0] aw_index;
    logic [AXIL_ADDR_W-AXIL_WORD_LSB-1:0] ar_index;
    logic                                 aw_aligned;
    logic                                 ar_aligned;
    // Global channel numbers behind the two lane lookups
    logic [2:0]                           adc_full_chan;
    logic [2:0]                           dac_full_chan;

    assign aw_index = awaddr[AXIL_ADDR_W-1:AXIL_WORD_LSB];
    assign ar_index = araddr[AXIL_ADDR_W-1:AXIL_WORD_LSB];
    assign aw_aligned = (awaddr[AXIL_WORD_LSB-1:0] == '0);
    assign ar_aligned = (araddr[AXIL_WORD_LSB-1:0] == '0);

    // Write channel, and the coefficient store it updates
    // Byte strobes are not supported, wstrb has no effect and every write is a full word
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= WR_IDLE;
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= OKAY;
            for (int i = 0; i < COEF_WORDS; i++) begin
                coef_mem[i] <= i[0] ? gain_reset : offset_reset;
            end
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (awready) begin
                        // Handshake edge, the write lands here
                        awready <= 1'b0;
                        wready <= 1'b0;
                        bvalid <= 1'b1;
                        wr_state <= WR_RESP;
                        if (aw_aligned) begin
                            coef_mem[aw_index] <= wdata[15:0];
                            bresp <= OKAY;
                        end else begin
                            bresp <= SLVERR;
                        end
                    end else if (awvalid && wvalid) begin
                        awready <= 1'b1;
                        wready <= 1'b1;
                    end
                end
                WR_RESP: begin
                    // No new address is taken until the response is gone
                    if (bready) begin
                        bvalid <= 1'b0;
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // Read channel, data is sign-extended from the low half
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
            arready <= 1'b0;
            rvalid <= 1'b0;
            rresp <= OKAY;
            rdata <= '0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (arready) begin
                        arready <= 1'b0;
                        rvalid <= 1'b1;
                        rd_state <= RD_DATA;
                        if (ar_aligned) begin
                            rdata <= {{(AXIL_DATA_W-16){coef_mem[ar_index][15]}},
                                      coef_mem[ar_index]};
                            rresp <= OKAY;
                        end else begin
                            rdata <= '0;
                            rresp <= SLVERR;
                        end
                    end else if (arvalid) begin
                        arready <= 1'b1;
                    end
                end
                RD_DATA: begin
                    if (rready) begin
                        rvalid <= 1'b0;
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // Lane lookups are combinational so a write is seen by the very next result
    assign adc_full_chan = ADC_CHAN_BASE + 3'(adc_chan);
    assign dac_full_chan = DAC_CHAN_BASE + 3'(dac_chan);
    assign adc_offset = coef_mem[{adc_full_chan, 1'b0}];
    assign adc_gain = coef_mem[{adc_full_chan, 1'b1}];
    assign dac_offset = coef_mem[{dac_full_chan, 1'b0}];
    assign dac_gain = coef_mem[{dac_full_chan, 1'b1}];

endmodule

`default_nettype wire

/* cal/cal_collect.sv */
// Collector that gathers both lanes' results into one eight-channel output frame
`default_nettype none
`timescale 1ns/10ps

module cal_collect (
    input  logic              clk,
    input  logic              rst,
    cal_result_if.collector   adc_result,
    cal_result_if.collector   dac_result,
    output cal_pkg::sample_t  out_0,
    output cal_pkg::sample_t  out_1,
    output cal_pkg::sample_t  out_2,
    output cal_pkg::sample_t  out_3,
    output cal_pkg::sample_t  out_4,
    output cal_pkg::sample_t  out_5,
    output cal_pkg::sample_t  out_6,
    output cal_pkg::sample_t  out_7,
    output logic              frame_valid
);
    import cal_pkg::*;

    // ADC results go to the lower half and DAC results to the upper half
    sample_t out_reg [0:2*LANE_CHANNELS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2 * LANE_CHANNELS; i++) begin
                out_reg[i] <= '0;
            end
            frame_valid <= 1'b0;
        end else begin
            if (adc_result.result_valid) begin
                out_reg[{1'b0, adc_result.result_chan}] <= adc_result.result_data;
            end
            if (dac_result.result_valid) begin
                out_reg[{1'b1, dac_result.result_chan}] <= dac_result.result_data;
            end
            // Both lanes start on the same strobe, so their last results coincide
            frame_valid <= adc_result.result_valid && adc_result.result_last &&
                           dac_result.result_valid && dac_result.result_last;
        end
    end

    assign out_0 = out_reg[0];
    assign out_1 = out_reg[1];
    assign out_2 = out_reg[2];
    assign out_3 = out_reg[3];
    assign out_4 = out_reg[4];
    assign out_5 = out_reg[5];
    assign out_6 = out_reg[6];
    assign out_7 = out_reg[7];

endmodule

`default_nettype wire

/* cal/cal_lane.sv */
// Four-channel calibration lane sharing one multiplier across its channels
`default_nettype none
`timescale 1ns/10ps

module cal_lane #(
    parameter int clamp_limit = 28000,
    parameter int frac_bits = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                sample_strobe,
    input  cal_pkg::sample_t    in_0,
    input  cal_pkg::sample_t    in_1,
    input  cal_pkg::sample_t    in_2,
    input  cal_pkg::sample_t    in_3,
    output cal_pkg::lane_chan_t coef_chan,
    input  cal_pkg::coef_t      coef_offset,
    input  cal_pkg::coef_t      coef_gain,
    cal_result_if.lane          result
);
    import cal_pkg::*;

    localparam lane_chan_t last_chan = lane_chan_t'(LANE_CHANNELS - 1);
    // Saturation bounds at the full product width
    localparam logic signed [32:0] sat_hi = 33'(clamp_limit);
    localparam logic signed [32:0] sat_lo = -sat_hi;

    lane_state_e state;
    lane_chan_t  chan;
    sample_t     frame [0:LANE_CHANNELS-1];
    sample_t     cal_value;

    // The register file answers in the same cycle for the channel in work
    assign coef_chan = chan;

    // Offset removal at 17 bits, full-width gain product, then fixed-point rescale
    always_comb begin
        logic signed [16:0] diff;
        logic signed [32:0] product;
        logic signed [32:0] scaled;
        diff = 17'(frame[chan]) - 17'(coef_offset);
        product = diff * coef_gain;
        scaled = product >>> frac_bits;
        if (scaled > sat_hi) begin
            cal_value = sat_hi[15:0];
        end else if (scaled < sat_lo) begin
            cal_value = sat_lo[15:0];
        end else begin
            cal_value = scaled[15:0];
        end
    end

    // Sequencer, a strobe seen while running is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            chan <= '0;
            result.result_valid <= 1'b0;
            result.result_last <= 1'b0;
        end else begin
            result.result_valid <= (state == RUN);
            result.result_last <= (state == RUN) && (chan == last_chan);
            case (state)
                IDLE: begin
                    if (sample_strobe) begin
                        chan <= '0;
                        state <= RUN;
                    end
                end
                RUN: begin
                    chan <= chan + 2'd1;
                    if (chan == last_chan) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Sample latch and result payload
    always_ff @(posedge clk) begin
        if (state == IDLE && sample_strobe) begin
            frame[0] <= in_0;
            frame[1] <= in_1;
            frame[2] <= in_2;
            frame[3] <= in_3;
        end
        result.result_data <= cal_value;
        result.result_chan <= chan;
    end

endmodule

`default_nettype wire

/* common/axil_pkg.sv */
// AXI4-Lite package with bus widths, response codes, channel states and the address map
`default_nettype none

package axil_pkg;

    localparam int AXIL_ADDR_W = 6;
    localparam int AXIL_DATA_W = 32;

    // Byte address bits below the coefficient word index
    // Channel c has its offset at word 2c and its gain at word 2c+1
    localparam int AXIL_WORD_LSB = 2;
    localparam int COEF_WORDS = 16;

    // First global channel of each lane, ADC on 0 to 3 and DAC on 4 to 7
    localparam logic [2:0] ADC_CHAN_BASE = 3'd0;
    localparam logic [2:0] DAC_CHAN_BASE = 3'd4;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // The handshake cycle lives inside the idle state, flagged by the ready outputs
    typedef enum logic {WR_IDLE, WR_RESP} axil_wr_state_e;
    typedef enum logic {RD_IDLE, RD_DATA} axil_rd_state_e;

endpackage

`default_nettype wire

/* common/cal_pkg.sv */
// Calibration package with the sample, coefficient and lane channel types
`default_nettype none

package cal_pkg;

    // Raw samples and calibrated results share one signed format
    typedef logic signed [15:0] sample_t;

    // Offsets are in raw counts, and gains are 6.10 fixed point
    typedef logic signed [15:0] coef_t;

    // Channel index within one lane
    typedef logic [1:0] lane_chan_t;

    // Each lane covers one side of the module, ADC or DAC
    localparam int LANE_CHANNELS = 4;

    // Lane sequencer states
    // IDLE waits for a sample strobe
    // RUN steps through the four channels, one per cycle
    typedef enum logic {
        IDLE,
        RUN
    } lane_state_e;

endpackage

`default_nettype wire

/* common/cal_result_if.sv */
// Result path that carries one lane's calibrated samples to the collector
`default_nettype none
`timescale 1ns/10ps

interface cal_result_if;
    import cal_pkg::*;

    // One calibrated sample per valid cycle, tagged with its lane channel
    logic       result_valid;
    lane_chan_t result_chan;
    sample_t    result_data;
    // High together with the result for the last lane channel
    logic       result_last;

    // The lane drives everything and the collector never stalls it
    modport lane (
        output result_valid,
        output result_chan,
        output result_data,
        output result_last
    );

    modport collector (
        input result_valid,
        input result_chan,
        input result_data,
        input result_last
    );

endinterface

`default_nettype wire

/* dv/cal_checker.sv */
// Bound assertions for the calibrator's AXI4-Lite responses and its frame pulse
`default_nettype none
`timescale 1ns/10ps

module cal_checker (
    input logic clk,
    input logic rst,
    input logic awready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic frame_valid
);

    // A write response stays up until the master takes it
    assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    // The same holds for read data
    assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // One pulse per frame
    assert property (@(posedge clk) disable iff (rst) frame_valid |=> !frame_valid)
        else $error("frame_valid high for two cycles in a row");

    // The write address channel leaves reset not ready
    assert property (@(posedge clk) $fell(rst) |-> !awready)
        else $error("awready high in the first cycle after reset");

endmodule

bind cal_top cal_checker i_checker (
    .clk(clk),
    .rst(rst),
    .awready(awready),
    .bvalid(bvalid),
    .bready(bready),
    .rvalid(rvalid),
    .rready(rready),
    .frame_valid(frame_valid)
);

`default_nettype wire

/* dv/cal_tb.sv */
// Table-driven testbench for the sample calibrator over AXI4-Lite and sample frames
`default_nettype none
`timescale 1ns/10ps

module cal_tb;

    localparam int clamp_limit = 28000;
    localparam int frac_bits = 10;
    localparam int num_entries = 10;

    // Each step gives the channel to recalibrate, its new offset and gain, a mode and raw inputs
    // Mode bits from the top are write, LFSR inputs, unaligned access and a second strobe
    typedef struct packed {
        logic [2:0]   chan;
        logic [15:0]  offset;
        logic [15:0]  gain;
        logic [3:0]   mode;
        logic [127:0] raw;
    } entry_t;

    logic         clk;
    logic         rst;
    logic         sample_strobe;
    logic [127:0] in_bus;
    wire  [127:0] out_bus;
    wire          frame_valid;
    logic [5:0]   awaddr;
    logic [5:0]   araddr;
    logic [31:0]  wdata;
    logic [3:0]   wstrb;
    logic         awvalid, wvalid, bready, arvalid, rready;
    wire          awready, wready, bvalid, arready, rvalid;
    wire  [1:0]   bresp;
    wire  [1:0]   rresp;
    wire  [31:0]  rdata;

    entry_t             tbl [0:num_entries-1];
    logic signed [15:0] model_offset [0:7];
    logic signed [15:0] model_gain [0:7];
    logic [15:0]        lfsr_state;
    int                 frame_count;
    int                 expected_frames;

    cal_top #(
        .clamp_limit(clamp_limit),
        .frac_bits(frac_bits)
    ) i_dut (
        .in_0(in_bus[15:0]),
        .in_1(in_bus[31:16]),
        .in_2(in_bus[47:32]),
        .in_3(in_bus[63:48]),
        .in_4(in_bus[79:64]),
        .in_5(in_bus[95:80]),
        .in_6(in_bus[111:96]),
        .in_7(in_bus[127:112]),
        .out_0(out_bus[15:0]),
        .out_1(out_bus[31:16]),
        .out_2(out_bus[47:32]),
        .out_3(out_bus[63:48]),
        .out_4(out_bus[79:64]),
        .out_5(out_bus[95:80]),
        .out_6(out_bus[111:96]),
        .out_7(out_bus[127:112]),
        .bresp(bresp),
        .rresp(rresp),
        .*
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Counts frame_valid pulses, so an accepted extra strobe would show up here
    always @(posedge clk) begin
        if (rst) begin
            frame_count <= 0;
        end else if (frame_valid) begin
            frame_count <= frame_count + 1;
        end
    end

    // Each entry needs well under 40 cycles and the extra covers reset and slack
    initial begin
        repeat (num_entries * 40 + 200) @(posedge clk);
        abort_run("Timeout, the test sequence did not finish in time");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_equal(input logic signed [31:0] actual,
                               input logic signed [31:0] expected, input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            abort_run("A DUT response differs from its expected value");
        end
    endtask

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_word(output logic [15:0] w);
        w = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
    endtask

    // Reference model that removes the offset, applies the 6.10 gain, rescales and clamps
    function automatic logic signed [15:0] calibrate(input logic signed [15:0] raw,
                                                     input logic signed [15:0] offset,
                                                     input logic signed [15:0] gain);
        longint value;
        value = (longint'(raw) - longint'(offset)) * longint'(gain);
        value = value >>> frac_bits;
        if (value > clamp_limit) begin
            value = clamp_limit;
        end else if (value < -clamp_limit) begin
            value = -clamp_limit;
        end
        return value[15:0];
    endfunction

    task automatic axil_write(input logic [5:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        awaddr <= addr;
        wdata <= data;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        bready <= 1'b1;
        do begin
            @(posedge clk);
        end while (!awready);
        // Address and data are taken in the same cycle
        check_equal(wready, 1, "wready together with awready");
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!bvalid);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [5:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        araddr <= addr;
        arvalid <= 1'b1;
        rready <= 1'b1;
        do begin
            @(posedge clk);
        end while (!arready);
        arvalid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic check_outputs(input logic [127:0] raw);
        for (int k = 0; k < 8; k++) begin
            check_equal($signed(out_bus[16*k +: 16]),
                        calibrate(raw[16*k +: 16], model_offset[k], model_gain[k]),
                        $sformatf("out_%0d", k));
        end
    endtask

    // Strobe one frame and check its timing, its outputs and the frame count
    task automatic run_frame(input logic [127:0] raw, input logic restrobe);
        int waited;
        in_bus <= raw;
        sample_strobe <= 1'b1;
        @(posedge clk);
        sample_strobe <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            // Different inputs on a strobe that lands while the lanes run
            if (restrobe && waited == 1) begin
                in_bus <= ~raw;
                sample_strobe <= 1'b1;
            end else if (waited == 2) begin
                sample_strobe <= 1'b0;
            end
        end while (!frame_valid && waited < 20);
        if (!frame_valid) begin
            abort_run("frame_valid never came after a sample strobe");
        end
        // Seen one edge after the edge that raised it
        check_equal(waited - 1, 5, "cycles from strobe edge to frame_valid");
        expected_frames++;
        check_outputs(raw);
        repeat (6) @(posedge clk);
        check_equal(frame_count, expected_frames, "frame count");
        check_outputs(raw);
    endtask

    // Raw inputs run from in_7 on the left to in_0 on the right
    task automatic load_table();
        tbl[0] = {3'd0, 16'h0000, 16'h0400, 4'b0000, 128'h3E80F1230ABCA00050000001FF001234};
        tbl[1] = {3'd2, 16'h0064, 16'h0800, 4'b1000, 128'h01000200030004000500060007000800};
        tbl[2] = {3'd6, 16'hFFCE, 16'h0200, 4'b1100, 128'h0};
        tbl[3] = {3'd1, 16'h0000, 16'h7FFF, 4'b1000, 128'hC000400020001000F000E000C0004000};
        tbl[4] = {3'd5, 16'h8000, 16'h0400, 4'b1010, 128'h001000207FFF00400050006000700080};
        tbl[5] = {3'd3, 16'h0000, 16'hFC00, 4'b1101, 128'h0};
        tbl[6] = {3'd4, 16'h1000, 16'h0600, 4'b1110, 128'h0};
        tbl[7] = {3'd0, 16'hF000, 16'h0100, 4'b1101, 128'h0};
        tbl[8] = {3'd7, 16'h0000, 16'h8000, 4'b1100, 128'h0};
        tbl[9] = {3'd2, 16'h0000, 16'h0400, 4'b1011, 128'h80007FFF80017FFE0000FFFF6D609290};
    endtask

    initial begin
        entry_t       e;
        logic [127:0] raw;
        logic [15:0]  word;
        logic [31:0]  rd_value;
        logic [1:0]   resp;
        rst = 1'b1;
        sample_strobe = 1'b0;
        in_bus = '0;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        wstrb = 4'hF;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        arvalid = 1'b0;
        rready = 1'b0;
        lfsr_state = 16'd24990;
        expected_frames = 0;
        for (int k = 0; k < 8; k++) begin
            model_offset[k] = 16'sd0;
            model_gain[k] = 16'sd1024;
        end
        load_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_equal(frame_valid, 0, "frame_valid after reset");
        for (int k = 0; k < 8; k++) begin
            check_equal(out_bus[16*k +: 16], 0, $sformatf("out_%0d after reset", k));
        end
        for (int i = 0; i < num_entries; i++) begin
            e = tbl[i];
            if (e.mode[3]) begin
                axil_write({e.chan, 3'b000}, {16'h0000, e.offset}, resp);
                check_equal(resp, 0, "offset write response");
                axil_write({e.chan, 3'b100}, {16'h0000, e.gain}, resp);
                check_equal(resp, 0, "gain write response");
                model_offset[e.chan] = e.offset;
                model_gain[e.chan] = e.gain;
                axil_read({e.chan, 3'b000}, rd_value, resp);
                check_equal(rd_value, {{16{e.offset[15]}}, e.offset}, "offset readback");
                check_equal(resp, 0, "offset read response");
                axil_read({e.chan, 3'b100}, rd_value, resp);
                check_equal(rd_value, {{16{e.gain[15]}}, e.gain}, "gain readback");
                check_equal(resp, 0, "gain read response");
            end
            if (e.mode[1]) begin
                // Unaligned accesses get SLVERR, and this data must land nowhere
                axil_write({e.chan, 3'b001}, 32'h0000_7777, resp);
                check_equal(resp, 2, "unaligned write response");
                axil_read({e.chan, 3'b110}, rd_value, resp);
                check_equal(resp, 2, "unaligned read response");
            end
            raw = e.raw;
            if (e.mode[2]) begin
                for (int k = 0; k < 8; k++) begin
                    random_word(word);
                    raw[16*k +: 16] = word;
                end
            end
            run_frame(raw, e.mode[0]);
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
common/cal_pkg.sv
common/axil_pkg.sv
common/cal_result_if.sv
cal/cal_coef_regs.sv
cal/cal_lane.sv
cal/cal_collect.sv
hdl/cal_top.sv
dv/cal_checker.sv
dv/cal_tb.sv

/* hdl/cal_top.sv */
// Sample calibrator top with AXI4-Lite coefficient access and eight calibrated channels
`default_nettype none
`timescale 1ns/10ps

module cal_top #(
    parameter int clamp_limit = 28000,
    parameter int frac_bits = 10
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 sample_strobe,
    input  cal_pkg::sample_t                     in_0,
    input  cal_pkg::sample_t                     in_1,
    input  cal_pkg::sample_t                     in_2,
    input  cal_pkg::sample_t                     in_3,
    input  cal_pkg::sample_t                     in_4,
    input  cal_pkg::sample_t                     in_5,
    input  cal_pkg::sample_t                     in_6,
    input  cal_pkg::sample_t                     in_7,
    output cal_pkg::sample_t                     out_0,
    output cal_pkg::sample_t                     out_1,
    output cal_pkg::sample_t                     out_2,
    output cal_pkg::sample_t                     out_3,
    output cal_pkg::sample_t                     out_4,
    output cal_pkg::sample_t                     out_5,
    output cal_pkg::sample_t                     out_6,
    output cal_pkg::sample_t                     out_7,
    output logic                                 frame_valid,
    input  logic [axil_pkg::AXIL_ADDR_W-1:0]     awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [axil_pkg::AXIL_DATA_W-1:0]     wdata,
    input  logic [axil_pkg::AXIL_DATA_W/8-1:0]   wstrb,
    input  logic                                 wvalid,
    output logic                                 wready,
    output axil_pkg::axil_resp_e                 bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    input  logic [axil_pkg::AXIL_ADDR_W-1:0]     araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [axil_pkg::AXIL_DATA_W-1:0]     rdata,
    output axil_pkg::axil_resp_e                 rresp,
    output logic                                 rvalid,
    input  logic                                 rready
);
    import cal_pkg::*;

    // Coefficient lookups, named as on the register file so they connect by name
    lane_chan_t adc_chan;
    lane_chan_t dac_chan;
    coef_t      adc_offset;
    coef_t      adc_gain;
    coef_t      dac_offset;
    coef_t      dac_gain;

    cal_result_if adc_result_bus ();
    cal_result_if dac_result_bus ();

    cal_coef_regs i_regs (.*);

    // ADC lane on inputs 0 to 3
    cal_lane #(
        .clamp_limit(clamp_limit),
        .frac_bits(frac_bits)
    ) i_adc_lane (
        .clk(clk),
        .rst(rst),
        .sample_strobe(sample_strobe),
        .in_0(in_0),
        .in_1(in_1),
        .in_2(in_2),
        .in_3(in_3),
        .coef_chan(adc_chan),
        .coef_offset(adc_offset),
        .coef_gain(adc_gain),
        .result(adc_result_bus)
    );

    // DAC lane on inputs 4 to 7
    cal_lane #(
        .clamp_limit(clamp_limit),
        .frac_bits(frac_bits)
    ) i_dac_lane (
        .clk(clk),
        .rst(rst),
        .sample_strobe(sample_strobe),
        .in_0(in_4),
        .in_1(in_5),
        .in_2(in_6),
        .in_3(in_7),
        .coef_chan(dac_chan),
        .coef_offset(dac_offset),
        .coef_gain(dac_gain),
        .result(dac_result_bus)
    );

    cal_collect i_collect (
        .clk(clk),
        .rst(rst),
        .adc_result(adc_result_bus),
        .dac_result(dac_result_bus),
        .out_0(out_0),
        .out_1(out_1),
        .out_2(out_2),
        .out_3(out_3),
        .out_4(out_4),
        .out_5(out_5),
        .out_6(out_6),
        .out_7(out_7),
        .frame_valid(frame_valid)
    );

endmodule

`default_nettype wire
